//--- build.f
source/rv_pkg.sv
source/stream_if.sv
source/stream_fifo.sv
source/reg_file.sv
source/scoreboard.sv
source/decode_stage.sv
source/decode_top.sv
test/tb_clock.sv
test/decode_assert.sv
test/decode_tb.sv

//--- source/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
  input  logic                          clk,
  input  logic                          rst,
  stream_if.sink                        f,
  stream_if.source                      u,
  output logic [rv_pkg::reg_addr_w-1:0] raddr1_o,
  output logic [rv_pkg::reg_addr_w-1:0] raddr2_o,
  input  logic [rv_pkg::xlen-1:0]       rdata1_i,
  input  logic [rv_pkg::xlen-1:0]       rdata2_i,
  input  logic [rv_pkg::num_regs-1:0]   busy_i,
  output logic                          issue_o,
  output logic [rv_pkg::reg_addr_w-1:0] issue_rd_o
);
  import rv_pkg::*;

  fetch_t held_q;
  logic held_valid;
  logic [31:0] inst;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic use_rs1;
  logic use_rs2;
  logic stall;
  logic take;
  logic fire;
  uop_t uop;

  assign inst   = held_q.inst;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign fire    = u.valid && u.ready;
  assign take    = f.valid && f.ready;
  assign f.ready = !held_valid || fire;
  assign stall   = (use_rs1 && busy_i[rs1]) || (use_rs2 && busy_i[rs2]);
  assign u.valid = held_valid && !stall;
  assign u.data  = uop;

  assign raddr1_o   = rs1;
  assign raddr2_o   = rs2;
  assign issue_o    = fire && uop.rd_we; // marks rd pending in the scoreboard.
  assign issue_rd_o = uop.rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      held_valid <= 1'b0;
    end else if (take) begin
      held_valid <= 1'b1;
    end else if (fire) begin
      held_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      held_q <= f.data;
    end
  end

  always_comb begin
    uop        = '0;
    uop.pc     = held_q.pc;
    uop.funct3 = funct3;
    uop.kind   = kind_illegal;
    uop.alu_op = alu_add;
    use_rs1    = 1'b0;
    use_rs2    = 1'b0;
    case (opcode)
      op_lui: begin
        uop.kind = kind_alu;
        uop.imm  = imm_u;
        uop.op2  = imm_u;
      end
      op_auipc: begin
        uop.kind = kind_alu;
        uop.imm  = imm_u;
        uop.op1  = held_q.pc;
        uop.op2  = imm_u;
      end
      op_jal: begin
        uop.kind   = kind_jump;
        uop.imm    = imm_j;
        uop.op1    = held_q.pc;
        uop.op2    = xlen'(4); // link value is pc + 4.
        uop.target = held_q.pc + imm_j;
      end
      op_jalr: begin
        uop.kind   = kind_jump;
        uop.imm    = imm_i;
        uop.op1    = held_q.pc;
        uop.op2    = xlen'(4);
        uop.target = (rdata1_i + imm_i) & ~xlen'(1);
        use_rs1    = 1'b1;
      end
      op_branch: begin
        uop.kind   = kind_branch;
        uop.alu_op = alu_sub; // compare, funct3 picks the condition.
        uop.imm    = imm_b;
        uop.op1    = rdata1_i;
        uop.op2    = rdata2_i;
        uop.target = held_q.pc + imm_b;
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
      end
      op_load: begin
        uop.kind = kind_load;
        uop.imm  = imm_i;
        uop.op1  = rdata1_i;
        uop.op2  = imm_i;
        use_rs1  = 1'b1;
      end
      op_store: begin
        uop.kind = kind_store;
        uop.imm  = imm_s;
        uop.op1  = rdata1_i;
        uop.op2  = rdata2_i;
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
      end
      op_imm: begin
        uop.kind   = kind_alu;
        uop.alu_op = (funct3 == 3'b101) ? alu_op_e'({inst[30], funct3}) :
                                          alu_op_e'({1'b0, funct3}); // only shifts use bit 30.
        uop.imm    = imm_i;
        uop.op1    = rdata1_i;
        uop.op2    = imm_i;
        use_rs1    = 1'b1;
      end
      op_reg: begin
        uop.kind   = kind_alu;
        uop.alu_op = alu_op_e'({inst[30], funct3});
        uop.op1    = rdata1_i;
        uop.op2    = rdata2_i;
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
      end
      op_fence: begin
        uop.kind = kind_fence;
        uop.imm  = imm_i;
      end
      op_system: begin
        uop.kind = kind_system;
        uop.imm  = imm_i; // csr number, not interpreted here.
      end
      default: begin
        uop.kind = kind_illegal;
      end
    endcase
    uop.rd_we = (uop.kind == kind_alu || uop.kind == kind_load || uop.kind == kind_jump) &&
                (rd != '0);
    uop.rd    = uop.rd_we ? rd : '0;
  end
endmodule

//--- source/decode_top.sv
`timescale 1ns/1ns

module decode_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  input  logic [rv_pkg::xlen-1:0]       in_pc_i,
  input  logic [31:0]                   in_inst_i,
  output logic                          uop_valid_o,
  input  logic                          uop_ready_i,
  output logic [rv_pkg::xlen-1:0]       uop_pc_o,
  output rv_pkg::uop_kind_e             uop_kind_o,
  output rv_pkg::alu_op_e               uop_alu_op_o,
  output logic [rv_pkg::xlen-1:0]       uop_op1_o,
  output logic [rv_pkg::xlen-1:0]       uop_op2_o,
  output logic [rv_pkg::xlen-1:0]       uop_imm_o,
  output logic [rv_pkg::xlen-1:0]       uop_target_o,
  output logic [rv_pkg::reg_addr_w-1:0] uop_rd_o,
  output logic                          uop_rd_we_o,
  input  logic                          wb_valid_i,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd_i,
  input  logic [rv_pkg::xlen-1:0]       wb_data_i
);
  import rv_pkg::*;

  logic [reg_addr_w-1:0] raddr1;
  logic [reg_addr_w-1:0] raddr2;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic [num_regs-1:0] busy;
  logic issue;
  logic [reg_addr_w-1:0] issue_rd;

  stream_if #(.payload_t(fetch_t)) in_s ();
  stream_if #(.payload_t(fetch_t)) fetch_s ();
  stream_if #(.payload_t(uop_t)) uop_s ();
  stream_if #(.payload_t(uop_t)) out_s ();

  assign in_s.valid  = in_valid_i;
  assign in_s.data   = '{pc: in_pc_i, inst: in_inst_i};
  assign in_ready_o  = in_s.ready;

  assign out_s.ready  = uop_ready_i;
  assign uop_valid_o  = out_s.valid;
  assign uop_pc_o     = out_s.data.pc;
  assign uop_kind_o   = out_s.data.kind;
  assign uop_alu_op_o = out_s.data.alu_op;
  assign uop_op1_o    = out_s.data.op1;
  assign uop_op2_o    = out_s.data.op2;
  assign uop_imm_o    = out_s.data.imm;
  assign uop_target_o = out_s.data.target;
  assign uop_rd_o     = out_s.data.rd;
  assign uop_rd_we_o  = out_s.data.rd_we;

  stream_fifo #(.payload_t(fetch_t)) in_fifo (.clk(clk), .rst(rst), .s(in_s), .m(fetch_s));

  decode_stage decode (
    .clk       (clk),
    .rst       (rst),
    .f         (fetch_s),
    .u         (uop_s),
    .raddr1_o  (raddr1),
    .raddr2_o  (raddr2),
    .rdata1_i  (rdata1),
    .rdata2_i  (rdata2),
    .busy_i    (busy),
    .issue_o   (issue),
    .issue_rd_o(issue_rd)
  );

  stream_fifo #(.payload_t(uop_t)) out_fifo (.clk(clk), .rst(rst), .s(uop_s), .m(out_s));

  reg_file regs (
    .clk     (clk),
    .rst     (rst),
    .raddr1_i(raddr1),
    .raddr2_i(raddr2),
    .rdata1_o(rdata1),
    .rdata2_o(rdata2),
    .we_i    (wb_valid_i),
    .waddr_i (wb_rd_i),
    .wdata_i (wb_data_i)
  );

  scoreboard sb (
    .clk     (clk),
    .rst     (rst),
    .set_i   (issue),
    .set_rd_i(issue_rd),
    .clr_i   (wb_valid_i),
    .clr_rd_i(wb_rd_i),
    .busy_o  (busy)
  );
endmodule

//--- source/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::reg_addr_w-1:0] raddr1_i,
  input  logic [rv_pkg::reg_addr_w-1:0] raddr2_i,
  output logic [rv_pkg::xlen-1:0]       rdata1_o,
  output logic [rv_pkg::xlen-1:0]       rdata2_o,
  input  logic                          we_i,
  input  logic [rv_pkg::reg_addr_w-1:0] waddr_i,
  input  logic [rv_pkg::xlen-1:0]       wdata_i
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [num_regs];
  logic wr_en;

  assign wr_en = we_i && (waddr_i != '0); // x0 is never written.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // write-through so a same-cycle writeback is seen by decode.
  assign rdata1_o = (raddr1_i == '0) ? '0 :
                    (wr_en && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 :
                    (wr_en && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];
endmodule

//--- source/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs = 2 ** reg_addr_w;
  localparam int fifo_depth = 2;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_fence  = 7'b0001111; // misc-mem, fence.i lives here.
  localparam logic [6:0] op_system = 7'b1110011;

  // encoding is {funct7[5], funct3}.
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_sub  = 4'b1000,
    alu_sra  = 4'b1101
  } alu_op_e;

  typedef enum logic [2:0] {
    kind_alu,
    kind_load,
    kind_store,
    kind_branch,
    kind_jump,
    kind_system,
    kind_fence,
    kind_illegal
  } uop_kind_e;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
  } fetch_t;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    uop_kind_e             kind;
    alu_op_e               alu_op;
    logic [xlen-1:0]       op1;
    logic [xlen-1:0]       op2;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       target;
    logic [reg_addr_w-1:0] rd;
    logic                  rd_we;
    logic [2:0]            funct3;
  } uop_t;

endpackage

//--- source/scoreboard.sv
`timescale 1ns/1ns

module scoreboard (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          set_i,
  input  logic [rv_pkg::reg_addr_w-1:0] set_rd_i,
  input  logic                          clr_i,
  input  logic [rv_pkg::reg_addr_w-1:0] clr_rd_i,
  output logic [rv_pkg::num_regs-1:0]   busy_o
);
  import rv_pkg::*;

  logic [num_regs-1:0] pending;
  logic [num_regs-1:0] set_mask;
  logic [num_regs-1:0] clr_mask;

  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    if (set_i && set_rd_i != '0) set_mask[set_rd_i] = 1'b1; // x0 never pending.
    if (clr_i) clr_mask[clr_rd_i] = 1'b1;
  end

  assign busy_o = pending & ~clr_mask; // clear is visible at once.

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      pending <= busy_o | set_mask; // a new owner wins over the old writeback.
    end
  end
endmodule

//--- source/stream_fifo.sv
`timescale 1ns/1ns

module stream_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  stream_if.sink   s,
  stream_if.source m
);
  import rv_pkg::*;

  payload_t slot [fifo_depth];
  logic [$clog2(fifo_depth)-1:0] wr_ptr;
  logic [$clog2(fifo_depth)-1:0] rd_ptr;
  logic [$clog2(fifo_depth+1)-1:0] count;
  logic push;
  logic pop;

  function automatic logic [$clog2(fifo_depth)-1:0] next_ptr(
    input logic [$clog2(fifo_depth)-1:0] p
  );
    return (p == ($clog2(fifo_depth))'(fifo_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign s.ready = count < ($clog2(fifo_depth+1))'(fifo_depth);
  assign m.valid = count != '0;
  assign m.data  = slot[rd_ptr]; // straight from storage.
  assign push    = s.valid && s.ready;
  assign pop     = m.valid && m.ready;

  always_ff @(posedge clk) begin
    if (push) begin
      slot[wr_ptr] <= s.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop) count <= count + 1'b1;
      else if (!push && pop) count <= count - 1'b1;
    end
  end
endmodule

//--- source/stream_if.sv
`timescale 1ns/1ns

interface stream_if #(
  parameter type payload_t = logic
) ();
  logic     valid;
  logic     ready;
  payload_t data;

  modport source (
    output valid,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    output ready
  );
endinterface

//--- test/decode_assert.sv
`timescale 1ns/1ns

module decode_assert (
  input logic                          clk,
  input logic                          rst,
  input logic                          valid_i,
  input logic                          ready_i,
  input logic                          in_ready_i,
  input logic [rv_pkg::xlen-1:0]       pc_i,
  input logic [rv_pkg::xlen-1:0]       op1_i,
  input logic [rv_pkg::xlen-1:0]       op2_i,
  input logic [rv_pkg::xlen-1:0]       imm_i,
  input logic [rv_pkg::xlen-1:0]       target_i,
  input logic [rv_pkg::reg_addr_w-1:0] rd_i
);
  int failures = 0; // read by the testbench at the end of the run.

  reset_idle: assert property (@(posedge clk) rst |=> !valid_i && in_ready_i)
    else begin
      failures++;
      $error("micro-op valid or input not ready right after reset");
    end

  valid_holds: assert property (@(posedge clk) disable iff (rst)
      valid_i && !ready_i |=> valid_i)
    else begin
      failures++;
      $error("uop_valid_o dropped before the micro-op was taken");
    end

  data_stable: assert property (@(posedge clk) disable iff (rst)
      valid_i && !ready_i |=> $stable({pc_i, op1_i, op2_i, imm_i, target_i, rd_i}))
    else begin
      failures++;
      $error("micro-op fields changed while stalled");
    end
endmodule

bind decode_top decode_assert checks (
  .clk       (clk),
  .rst       (rst),
  .valid_i   (uop_valid_o),
  .ready_i   (uop_ready_i),
  .in_ready_i(in_ready_o),
  .pc_i      (uop_pc_o),
  .op1_i     (uop_op1_o),
  .op2_i     (uop_op2_o),
  .imm_i     (uop_imm_o),
  .target_i  (uop_target_o),
  .rd_i      (uop_rd_o)
);

//--- test/decode_tb.sv
`timescale 1ns/1ns

module decode_tb;
  import rv_pkg::*;

  localparam int wb_lag = 4; // cycles from a micro-op leaving to its writeback.

  typedef struct {
    logic [31:0] pc;
    logic [31:0] inst;
    uop_kind_e   kind;
    alu_op_e     alu_op;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] imm;
    logic [31:0] target;
    logic [4:0]  rd;
    logic [31:0] wb_data;
    int          dep;
  } row_t;

  typedef struct {
    string name;
    bit    bp;
    int    first;
    int    count;
    int    pre_first;
    int    pre_count;
  } test_t;

  typedef struct {
    logic [4:0]  rd;
    logic [31:0] data;
    int          due;
  } wb_t;

  logic        clk;
  logic        rst;
  logic        in_valid_i;
  logic        in_ready_o;
  logic [31:0] in_pc_i;
  logic [31:0] in_inst_i;
  logic        uop_valid_o;
  logic        uop_ready_i;
  logic [31:0] uop_pc_o;
  uop_kind_e   uop_kind_o;
  alu_op_e     uop_alu_op_o;
  logic [31:0] uop_op1_o;
  logic [31:0] uop_op2_o;
  logic [31:0] uop_imm_o;
  logic [31:0] uop_target_o;
  logic [4:0]  uop_rd_o;
  logic        uop_rd_we_o;
  logic        wb_valid_i;
  logic [4:0]  wb_rd_i;
  logic [31:0] wb_data_i;

  row_t  rows[$];
  test_t tests[$];
  wb_t   pre_q[$];
  wb_t   wb_q[$];
  int    expect_q[$];
  int    wb_cycle[32]; // cycle of the last writeback per register in this test.
  int    cycle = 0;
  int    limit = 0;
  int    errors = 0;
  int    test_errors = 0;
  int    got = 0;
  int    passed = 0;
  int    failed = 0;
  bit    bp_on = 1'b0;
  string cur_name = "reset";

  tb_clock clock_gen (.clk_o(clk), .rst_o(rst));

  decode_top uut (.*);

  function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd,
                                         logic [6:0] op);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), op};
  endfunction

  function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, logic [6:0] op);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
  endfunction

  function automatic logic [31:0] s_type(int imm, int rs2, int rs1, int f3);
    logic [11:0] i;
    i = 12'(imm);
    return {i[11:5], 5'(rs2), 5'(rs1), 3'(f3), i[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_type(int imm, int rs2, int rs1, int f3);
    logic [12:0] i;
    i = 13'(imm);
    return {i[12], i[10:5], 5'(rs2), 5'(rs1), 3'(f3), i[4:1], i[11], op_branch};
  endfunction

  function automatic logic [31:0] u_type(int imm20, int rd, logic [6:0] op);
    return {20'(imm20), 5'(rd), op};
  endfunction

  function automatic logic [31:0] j_type(int imm, int rd);
    logic [20:0] i;
    i = 21'(imm);
    return {i[20], i[10:1], i[11], i[19:12], 5'(rd), op_jal};
  endfunction

  function automatic void new_test(string name, bit bp);
    test_t t;
    t.name      = name;
    t.bp        = bp;
    t.first     = rows.size();
    t.count     = 0;
    t.pre_first = pre_q.size();
    t.pre_count = 0;
    tests.push_back(t);
  endfunction

  function automatic void preload(int rd, logic [31:0] data);
    wb_t w;
    w.rd   = 5'(rd);
    w.data = data;
    w.due  = 0;
    pre_q.push_back(w);
    tests[tests.size()-1].pre_count++;
  endfunction

  // pc of each row is 0x1000 * test number + 4 * position in the test.
  function automatic void expect_uop(logic [31:0] inst, uop_kind_e kind, alu_op_e alu_op,
                                     logic [31:0] op1, logic [31:0] op2, logic [31:0] imm,
                                     logic [31:0] target, int rd, logic [31:0] wb_data = 0,
                                     int dep = 0);
    row_t r;
    int t;
    t = tests.size() - 1;
    r.pc      = 32'h1000 * tests.size() + 4 * tests[t].count;
    r.inst    = inst;
    r.kind    = kind;
    r.alu_op  = alu_op;
    r.op1     = op1;
    r.op2     = op2;
    r.imm     = imm;
    r.target  = target;
    r.rd      = 5'(rd);
    r.wb_data = wb_data;
    r.dep     = dep;
    rows.push_back(r);
    tests[t].count++;
  endfunction

  function automatic void build_table();
    new_test("reset_state", 1'b0);
    expect_uop(r_type(0, 7, 6, 0, 3, op_reg), kind_alu, alu_add, 0, 0, 0, 0, 3, 32'h33);
    expect_uop(i_type(16, 18, 0, 17, op_imm), kind_alu, alu_add, 0, 32'h10, 32'h10, 0, 17,
               32'h17);

    new_test("alu_decode", 1'b0);
    preload(1, 32'h8000_0010);
    preload(2, 32'h0000_0003);
    expect_uop(r_type(0, 2, 1, 0, 4, op_reg), kind_alu, alu_add, 32'h8000_0010, 3, 0, 0, 4,
               32'h44);
    expect_uop(r_type(32, 2, 1, 0, 5, op_reg), kind_alu, alu_sub, 32'h8000_0010, 3, 0, 0, 5,
               32'h55);
    expect_uop(r_type(32, 2, 1, 5, 6, op_reg), kind_alu, alu_sra, 32'h8000_0010, 3, 0, 0, 6,
               32'h66);
    expect_uop(i_type(-5, 1, 2, 7, op_imm), kind_alu, alu_slt, 32'h8000_0010, 32'hffff_fffb,
               32'hffff_fffb, 0, 7, 32'h77);
    expect_uop(i_type(32'h7ff, 2, 4, 8, op_imm), kind_alu, alu_xor, 3, 32'h7ff, 32'h7ff, 0, 8,
               32'h88);

    new_test("imm_formats", 1'b0);
    preload(10, 32'h0000_4001);
    preload(11, 32'h0000_00ab);
    expect_uop(u_type(32'habcde, 12, op_lui), kind_alu, alu_add, 0, 32'habcd_e000,
               32'habcd_e000, 0, 12, 32'h12);
    expect_uop(u_type(1, 13, op_auipc), kind_alu, alu_add, 32'h3004, 32'h1000, 32'h1000, 0,
               13, 32'h13);
    expect_uop(j_type(-16, 14), kind_jump, alu_add, 32'h3008, 4, 32'hffff_fff0, 32'h2ff8,
               14, 32'h14);
    expect_uop(i_type(16, 10, 0, 15, op_jalr), kind_jump, alu_add, 32'h300c, 4, 32'h10,
               32'h4010, 15, 32'h15); // 0x4011 with bit 0 cleared.
    expect_uop(b_type(-32, 11, 10, 1), kind_branch, alu_sub, 32'h4001, 32'hab, 32'hffff_ffe0,
               32'h2ff0, 0);
    expect_uop(i_type(-4, 10, 2, 16, op_load), kind_load, alu_add, 32'h4001, 32'hffff_fffc,
               32'hffff_fffc, 0, 16, 32'h16);
    expect_uop(s_type(-256, 11, 10, 2), kind_store, alu_add, 32'h4001, 32'hab, 32'hffff_ff00,
               0, 0);

    new_test("hazard_stall", 1'b0);
    preload(20, 32'h100);
    expect_uop(i_type(5, 20, 0, 21, op_imm), kind_alu, alu_add, 32'h100, 5, 5, 0, 21,
               32'h5a5a);
    expect_uop(r_type(0, 20, 21, 0, 22, op_reg), kind_alu, alu_add, 32'h5a5a, 32'h100, 0, 0,
               22, 32'h22, 21); // waits for x21.
    expect_uop(i_type(1, 20, 4, 23, op_imm), kind_alu, alu_xor, 32'h100, 1, 1, 0, 23, 32'h23);

    new_test("back_pressure", 1'b1);
    preload(24, 32'h1111_0000);
    preload(25, 32'h0000_2222);
    expect_uop(r_type(0, 25, 24, 0, 26, op_reg), kind_alu, alu_add, 32'h1111_0000, 32'h2222,
               0, 0, 26, 32'h526);
    expect_uop(r_type(32, 25, 24, 0, 27, op_reg), kind_alu, alu_sub, 32'h1111_0000, 32'h2222,
               0, 0, 27, 32'h527);
    expect_uop(r_type(0, 25, 24, 6, 28, op_reg), kind_alu, alu_or, 32'h1111_0000, 32'h2222,
               0, 0, 28, 32'h528);
    expect_uop(r_type(0, 25, 24, 7, 29, op_reg), kind_alu, alu_and, 32'h1111_0000, 32'h2222,
               0, 0, 29, 32'h529);
    expect_uop(r_type(0, 25, 24, 1, 30, op_reg), kind_alu, alu_sll, 32'h1111_0000, 32'h2222,
               0, 0, 30, 32'h530);
    expect_uop(r_type(0, 25, 24, 3, 31, op_reg), kind_alu, alu_sltu, 32'h1111_0000, 32'h2222,
               0, 0, 31, 32'h531);
    expect_uop(r_type(0, 25, 24, 5, 3, op_reg), kind_alu, alu_srl, 32'h1111_0000, 32'h2222,
               0, 0, 3, 32'h503);
    expect_uop(i_type(32'hf0, 25, 7, 4, op_imm), kind_alu, alu_and, 32'h2222, 32'hf0, 32'hf0,
               0, 4, 32'h504);
    expect_uop(i_type(-1, 24, 6, 5, op_imm), kind_alu, alu_or, 32'h1111_0000, 32'hffff_ffff,
               32'hffff_ffff, 0, 5, 32'h505);
    expect_uop(i_type(4, 25, 1, 6, op_imm), kind_alu, alu_sll, 32'h2222, 4, 4, 0, 6, 32'h506);
    expect_uop(i_type(32'h403, 24, 5, 7, op_imm), kind_alu, alu_sra, 32'h1111_0000, 32'h403,
               32'h403, 0, 7, 32'h507); // srai sets bit 30.
    expect_uop(i_type(16, 25, 3, 8, op_imm), kind_alu, alu_sltu, 32'h2222, 32'h10, 32'h10, 0,
               8, 32'h508);

    new_test("special_cases", 1'b0);
    preload(0, 32'hdead_beef);
    expect_uop(r_type(0, 2, 1, 0, 0, op_reg), kind_alu, alu_add, 32'h8000_0010, 3, 0, 0, 0);
    expect_uop(r_type(0, 0, 0, 0, 9, op_reg), kind_alu, alu_add, 0, 0, 0, 0, 9, 32'h99);
    expect_uop(32'hffff_ffff, kind_illegal, alu_add, 0, 0, 0, 0, 0);
    expect_uop(i_type(0, 0, 1, 0, op_fence), kind_fence, alu_add, 0, 0, 0, 0, 0);
    expect_uop(i_type(32'h300, 0, 2, 10, op_system), kind_system, alu_add, 0, 0, 32'h300, 0,
               0);
  endfunction

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_field(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("Mismatch %s %s: expected %h, actual %h", cur_name, field, exp, act);
      note_error();
    end
  endtask

  task automatic take_uop();
    row_t r;
    wb_t w;
    assert (expect_q.size() != 0) else begin
      $display("%s: micro-op at pc %h arrived with none expected", cur_name, uop_pc_o);
      note_error();
    end
    if (expect_q.size() == 0) return;
    r = rows[expect_q.pop_front()];
    check_field("pc", r.pc, uop_pc_o);
    check_field("kind", r.kind, uop_kind_o);
    check_field("alu_op", r.alu_op, uop_alu_op_o);
    check_field("op1", r.op1, uop_op1_o);
    check_field("op2", r.op2, uop_op2_o);
    check_field("imm", r.imm, uop_imm_o);
    check_field("target", r.target, uop_target_o);
    check_field("rd", r.rd, uop_rd_o);
    check_field("rd_we", r.rd != 0, uop_rd_we_o);
    if (r.dep != 0) begin
      assert (wb_cycle[r.dep] >= 0) else begin
        $display("%s: micro-op at pc %h left before x%0d was written back",
                 cur_name, r.pc, r.dep);
        note_error();
      end
    end
    if (r.rd != 0) begin
      w.rd   = r.rd;
      w.data = r.wb_data;
      w.due  = cycle + wb_lag;
      wb_q.push_back(w);
    end
    got++;
  endtask

  task automatic drive_writeback();
    if (wb_q.size() != 0 && wb_q[0].due <= cycle) begin
      wb_valid_i = 1'b1;
      wb_rd_i    = wb_q[0].rd;
      wb_data_i  = wb_q[0].data;
      wb_cycle[wb_q[0].rd] = cycle;
      void'(wb_q.pop_front());
    end else begin
      wb_valid_i = 1'b0;
    end
  endtask

  task automatic send(input int idx);
    @(negedge clk);
    expect_q.push_back(idx);
    in_valid_i = 1'b1;
    in_pc_i    = rows[idx].pc;
    in_inst_i  = rows[idx].inst;
    while (!in_ready_o) @(negedge clk); // transfer lands on the next rising edge.
  endtask

  task automatic run_test(input int t);
    test_errors = 0;
    got         = 0;
    cur_name    = tests[t].name;
    foreach (wb_cycle[r]) wb_cycle[r] = -1;
    for (int p = 0; p < tests[t].pre_count; p++) begin
      wb_q.push_back(pre_q[tests[t].pre_first + p]);
    end
    while (wb_q.size() != 0) @(negedge clk);
    @(negedge clk);
    bp_on = tests[t].bp;
    for (int k = 0; k < tests[t].count; k++) begin
      send(tests[t].first + k);
    end
    @(negedge clk);
    in_valid_i = 1'b0;
    while (got < tests[t].count || wb_q.size() != 0) @(negedge clk);
    @(negedge clk);
    bp_on = 1'b0;
    if (test_errors == 0) passed++;
    else failed++;
    $display("%s: %0d micro-ops checked, %0d errors", cur_name, got, test_errors);
  endtask

  // output side, ready, monitor and writeback all move on the falling edge.
  initial begin
    void'($urandom(32'h8bbe));
    uop_ready_i = 1'b1;
    wb_valid_i  = 1'b0;
    wb_rd_i     = '0;
    wb_data_i   = '0;
    forever begin
      @(negedge clk);
      cycle++;
      uop_ready_i = bp_on ? ($urandom % 2 == 1) : 1'b1;
      if (uop_valid_o === 1'b1 && uop_ready_i) take_uop();
      drive_writeback();
    end
  end

  initial begin
    @(negedge rst);
    while (cycle <= limit) @(negedge clk);
    $display("timeout: micro-ops did not arrive");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    in_valid_i = 1'b0;
    in_pc_i    = '0;
    in_inst_i  = '0;
    build_table();
    limit = 40 * rows.size() + 200;
    @(negedge rst);
    @(negedge clk);
    check_field("uop_valid_o", 1'b0, uop_valid_o);
    check_field("in_ready_o", 1'b1, in_ready_o);
    foreach (tests[t]) begin
      run_test(t);
    end
    assert (uut.checks.failures == 0) else begin
      $display("handshake checker reported %0d failed assertions", uut.checks.failures);
      errors += uut.checks.failures;
    end
    $display("tests passed %0d, tests failed %0d, errors %0d", passed, failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end
endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  output logic clk_o,
  output logic rst_o
);
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o; // 100 ns period.
  end

  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end
endmodule
